// File: source/branch_metric.sv
`timescale 1ns/100ps
`include "fano_defs.svh"

module branch_metric (
    input  logic            clk,
    input  logic            nlocal_rst,
    input  logic            i_score,
    input  fano_pkg::hist_t i_hist,
    input  fano_pkg::sym_t  i_node_sym,
    input  logic            i_take_worse,
    output logic            o_vld,
    output fano_pkg::bm_t   o_bm,
    output logic            o_dec_bit
);
    import fano_pkg::*;

    sym_t exp_0, exp_1;         // Re-encoded branch per hypothesis
    bm_t  bm_0, bm_1;
    logic best_bit;
    logic pick_bit;

    // Hamming distance to metric
    function automatic bm_t dist_to_bm(input sym_t diff);
        case (diff)
            2'b00:   dist_to_bm = bm_t'(`FANO_BM_HIT);
            2'b11:   dist_to_bm = bm_t'(`FANO_BM_TWO);
            default: dist_to_bm = bm_t'(`FANO_BM_ONE);
        endcase
    endfunction

    ////////////////////////////////////////////////////
    // Re-encode both hypotheses
    ////////////////////////////////////////////////////
    assign exp_0 = {1'b0, ^({i_hist, 1'b0} & `FANO_GEN)};
    assign exp_1 = {1'b1, ^({i_hist, 1'b1} & `FANO_GEN)};

    assign bm_0 = dist_to_bm(exp_0 ^ i_node_sym);
    assign bm_1 = dist_to_bm(exp_1 ^ i_node_sym);

    assign best_bit = (bm_1 > bm_0);          // Tie goes to 0
    assign pick_bit = best_bit ^ i_take_worse;

    always_ff @(posedge clk) begin
        if (!nlocal_rst)
            o_vld <= 1'b0;
        else
            o_vld <= i_score;                 // Fixed one cycle latency
    end

    always_ff @(posedge clk) begin
        if (i_score) begin
            o_bm      <= pick_bit ? bm_1 : bm_0;
            o_dec_bit <= pick_bit;
        end
    end

endmodule

// File: source/branch_store.sv
`timescale 1ns/100ps
`include "fano_defs.svh"

module branch_store (
    input  logic              clk,
    input  logic              nlocal_rst,
    input  logic              i_sym_vld,
    input  fano_pkg::sym_t    i_sym,
    input  fano_pkg::node_ptr_t i_node,
    output logic              o_shift,
    output logic              o_full,
    output fano_pkg::sym_t    o_node_sym
);
    import fano_pkg::*;

    window_t             sh_d;      // Received info bits
    window_t             sh_p;      // Received parity bits
    logic [`FANO_PTR_W:0] fill_cnt; // Saturates at window depth
    node_ptr_t           rd_idx;

    assign o_shift = i_sym_vld;     // Same edge for every block

    always_ff @(posedge clk) begin
        if (!nlocal_rst) begin
            sh_d     <= '0;
            sh_p     <= '0;
            fill_cnt <= '0;
        end else if (i_sym_vld) begin
            sh_d <= {sh_d[`FANO_DEPTH-2:0], i_sym[1]};
            sh_p <= {sh_p[`FANO_DEPTH-2:0], i_sym[0]};
            if (!o_full)
                fill_cnt <= fill_cnt + 1'b1;
        end
    end

    assign o_full = (fill_cnt == `FANO_DEPTH);

    // Node n scores the branch one step newer than itself
    assign rd_idx = (i_node == '0) ? '0 : node_ptr_t'(i_node - 1'b1);

    assign o_node_sym = {sh_d[rd_idx], sh_p[rd_idx]};

endmodule

// File: source/fano_control.sv
`timescale 1ns/100ps
`include "fano_defs.svh"

module fano_control (
    input  logic                clk,
    input  logic                nlocal_rst,
    input  logic                i_shift,
    input  fano_pkg::metric_t   i_delta_t,
    input  logic                i_bm_vld,
    input  fano_pkg::bm_t       i_bm,
    input  logic                i_dec_bit,
    input  logic                i_worse,
    input  fano_pkg::metric_t   i_prev_metric,
    output fano_pkg::node_ptr_t o_node,
    output logic                o_score,
    output logic                o_take_worse,
    output logic                o_fwd,
    output logic                o_dec_bit,
    output fano_pkg::metric_t   o_node_metric,
    output logic                o_set_worse
);
    import fano_pkg::*;

    search_state_e state, state_nxt;
    node_ptr_t     node;
    metric_t       thr;             // Running threshold
    metric_t       cur_met;         // Metric of the node at the pointer
    metric_t       sum;
    metric_t       thr_hi;          // Threshold plus one step
    metric_t       thr_lo;          // Threshold minus one step
    logic          worse_r;         // Current score uses the worse branch
    logic          back;
    logic          thr_up, thr_dn;
    logic signed [`FANO_PTR_W+1:0] node_calc;

    // Signed add clamped to the metric range
    function automatic metric_t sat_add(input metric_t a, input metric_t b);
        logic signed [`FANO_MET_W:0] full;
        full = a + b;
        if (full > $signed({1'b0, metric_t'(`FANO_MET_MAX)}))
            sat_add = `FANO_MET_MAX;
        else if (full < $signed({1'b1, metric_t'(`FANO_MET_MIN)}))
            sat_add = `FANO_MET_MIN;
        else
            sat_add = metric_t'(full);
    endfunction

    assign sum    = sat_add(cur_met, metric_t'(i_bm));
    assign thr_hi = sat_add(thr, i_delta_t);
    assign thr_lo = sat_add(thr, -i_delta_t);

    ////////////////////////////////////////////////////
    // Search FSM
    ////////////////////////////////////////////////////
    always_comb begin
        state_nxt    = state;
        o_score      = 1'b0;
        o_take_worse = worse_r;
        o_fwd        = 1'b0;
        o_set_worse  = 1'b0;
        back         = 1'b0;
        thr_up       = 1'b0;
        thr_dn       = 1'b0;
        case (state)
            INIT: state_nxt = IDLE;
            IDLE: begin
                if (node != '0) begin           // Undecoded branches pending
                    o_score      = 1'b1;
                    o_take_worse = 1'b0;
                    state_nxt    = SCORE;
                end
            end
            SCORE: begin
                if (i_bm_vld) begin
                    if (sum >= thr) begin
                        o_fwd       = 1'b1;
                        o_set_worse = worse_r;  // Remember worse branch taken
                        state_nxt   = FORWARD;
                    end else if (i_prev_metric >= thr) begin
                        back      = 1'b1;
                        state_nxt = BACKWARD;
                    end else begin
                        thr_dn    = 1'b1;
                        state_nxt = IDLE;
                    end
                end
            end
            FORWARD: begin
                // Tighten only on first visit of this node
                if (i_prev_metric < thr_hi && cur_met >= thr_hi)
                    thr_up = 1'b1;
                else
                    state_nxt = IDLE;
            end
            BACKWARD: begin
                if (!i_worse) begin             // Try the other branch here
                    o_score      = 1'b1;
                    o_take_worse = 1'b1;
                    state_nxt    = SCORE;
                end else if (i_prev_metric >= thr) begin
                    back = 1'b1;                // Retreat one more node
                end else begin
                    thr_dn    = 1'b1;
                    state_nxt = IDLE;
                end
            end
            default: state_nxt = INIT;
        endcase
    end

    // Shift and move may land on the same edge
    assign node_calc = $signed({2'b00, node}) + i_shift + back - o_fwd;

    always_ff @(posedge clk) begin
        if (!nlocal_rst) begin
            state   <= INIT;
            node    <= '0;
            thr     <= '0;
            cur_met <= '0;
            worse_r <= 1'b0;
        end else begin
            state <= state_nxt;
            if (node_calc > `FANO_DEPTH-1)
                node <= node_ptr_t'(`FANO_DEPTH-1);   // Saturate at oldest
            else if (node_calc < 0)
                node <= '0;
            else
                node <= node_ptr_t'(node_calc);
            if (o_score)
                worse_r <= o_take_worse;
            if (o_fwd)
                cur_met <= sum;
            else if (back)
                cur_met <= i_prev_metric;
            if (thr_up)
                thr <= thr_hi;
            else if (thr_dn)
                thr <= thr_lo;
        end
    end

    assign o_node        = node;
    assign o_dec_bit     = i_dec_bit;       // Bit of the chosen hypothesis
    assign o_node_metric = sum;

endmodule

// File: source/fano_decoder.sv
`timescale 1ns/100ps

module fano_decoder (
    input  logic              clk,
    input  logic              nlocal_rst,
    input  logic              i_sym_vld,
    input  fano_pkg::sym_t    i_sym,
    input  fano_pkg::metric_t i_delta_t,
    output logic              o_bit_vld,
    output logic              o_bit
);
    import fano_pkg::*;

    ////////////////////////////////////////////////////
    // Internal links
    ////////////////////////////////////////////////////
    logic      shift, full;
    sym_t      node_sym;
    node_ptr_t node;
    hist_t     hist;
    logic      score, take_worse;
    logic      bm_vld, bm_bit;
    bm_t       bm;
    logic      fwd, dec_bit, set_worse, worse;
    metric_t   node_metric, prev_metric;

    branch_store branch_store_inst (
        .clk        (clk),
        .nlocal_rst (nlocal_rst),
        .i_sym_vld  (i_sym_vld),
        .i_sym      (i_sym),
        .i_node     (node),
        .o_shift    (shift),
        .o_full     (full),
        .o_node_sym (node_sym)
    );

    path_memory path_memory_inst (
        .clk           (clk),
        .nlocal_rst    (nlocal_rst),
        .i_shift       (shift),
        .i_full        (full),
        .i_node        (node),
        .i_fwd         (fwd),
        .i_dec_bit     (dec_bit),
        .i_node_metric (node_metric),
        .i_set_worse   (set_worse),
        .o_hist        (hist),
        .o_worse       (worse),
        .o_prev_metric (prev_metric),
        .o_bit_vld     (o_bit_vld),
        .o_bit         (o_bit)
    );

    branch_metric branch_metric_inst (
        .clk          (clk),
        .nlocal_rst   (nlocal_rst),
        .i_score      (score),
        .i_hist       (hist),
        .i_node_sym   (node_sym),
        .i_take_worse (take_worse),
        .o_vld        (bm_vld),
        .o_bm         (bm),
        .o_dec_bit    (bm_bit)
    );

    fano_control fano_control_inst (
        .clk           (clk),
        .nlocal_rst    (nlocal_rst),
        .i_shift       (shift),
        .i_delta_t     (i_delta_t),
        .i_bm_vld      (bm_vld),
        .i_bm          (bm),
        .i_dec_bit     (bm_bit),
        .i_worse       (worse),
        .i_prev_metric (prev_metric),
        .o_node        (node),
        .o_score       (score),
        .o_take_worse  (take_worse),
        .o_fwd         (fwd),
        .o_dec_bit     (dec_bit),
        .o_node_metric (node_metric),
        .o_set_worse   (set_worse)
    );

endmodule

// File: source/fano_defs.svh
`ifndef FANO_DEFS_SVH
`define FANO_DEFS_SVH

////////////////////////////////////////////////////
// Window and code
////////////////////////////////////////////////////
`define FANO_DEPTH   64            // Branches held in the search window
`define FANO_K       12            // Constraint length
`define FANO_GEN     12'hD1B       // Parity taps, bit 0 is the newest info bit
`define FANO_PTR_W   6             // Node index width

////////////////////////////////////////////////////
// Metrics
////////////////////////////////////////////////////
`define FANO_MET_W   16            // Path metric and threshold width
`define FANO_MET_MIN {1'b1, {(`FANO_MET_W-1){1'b0}}}
`define FANO_MET_MAX {1'b0, {(`FANO_MET_W-1){1'b1}}}
`define FANO_BM_HIT  1             // Both bits agree
`define FANO_BM_ONE  -4            // One bit differs
`define FANO_BM_TWO  -9            // Both bits differ

// Spacing between input strobes, in clocks
`define FANO_MIN_GAP 48

`endif

// File: source/fano_pkg.sv
`include "fano_defs.svh"

package fano_pkg;

    ////////////////////////////////////////////////////
    // Vector types
    ////////////////////////////////////////////////////
    typedef logic [1:0]                    sym_t;       // [1] info, [0] parity
    typedef logic [`FANO_PTR_W-1:0]        node_ptr_t;  // 0 is the newest node
    typedef logic signed [`FANO_MET_W-1:0] metric_t;    // Path metric or threshold
    typedef logic signed [4:0]             bm_t;        // Single branch metric
    typedef logic [`FANO_DEPTH-1:0]        window_t;    // One bit per window node
    typedef logic [`FANO_K-2:0]            hist_t;      // Encoder memory behind a node

    ////////////////////////////////////////////////////
    // Search controller
    ////////////////////////////////////////////////////
    typedef enum logic [2:0] {
        INIT,       // One cycle after reset
        IDLE,       // Waiting for undecoded branches
        SCORE,      // Branch metric in flight
        FORWARD,    // Moved deeper, tightening threshold
        BACKWARD    // Moved back, choosing worse branch or retreat
    } search_state_e;

endpackage

// File: source/path_memory.sv
`timescale 1ns/100ps
`include "fano_defs.svh"

module path_memory (
    input  logic                clk,
    input  logic                nlocal_rst,
    input  logic                i_shift,
    input  logic                i_full,
    input  fano_pkg::node_ptr_t i_node,
    input  logic                i_fwd,
    input  logic                i_dec_bit,
    input  fano_pkg::metric_t   i_node_metric,
    input  logic                i_set_worse,
    output fano_pkg::hist_t     o_hist,
    output logic                o_worse,
    output fano_pkg::metric_t   o_prev_metric,
    output logic                o_bit_vld,
    output logic                o_bit
);
    import fano_pkg::*;

    window_t   dec_bits;                    // Tentative decisions, index 0 newest
    window_t   worse;                       // Branch was taken as the worse one
    metric_t   node_met [`FANO_DEPTH];      // Metric after each decoded branch
    node_ptr_t wr_idx;
    logic [`FANO_DEPTH+`FANO_K-2:0] hist_ext; // Zero history beyond the window

    ////////////////////////////////////////////////////
    // Write position
    ////////////////////////////////////////////////////
    // A concurrent shift moves the target one step older
    assign wr_idx = i_shift ? i_node : node_ptr_t'(i_node - 1'b1);

    always_ff @(posedge clk) begin
        if (!nlocal_rst) begin
            dec_bits  <= '0;
            worse     <= '0;
            o_bit_vld <= 1'b0;
            node_met[0] <= '0;                  // Origin of the tree
            for (int i = 1; i < `FANO_DEPTH; i++)
                node_met[i] <= `FANO_MET_MIN;   // Nothing to go back to
        end else begin
            o_bit_vld <= i_shift & i_full;
            if (i_shift) begin
                dec_bits <= {dec_bits[`FANO_DEPTH-2:0], 1'b0};
                worse    <= {worse[`FANO_DEPTH-2:0], 1'b0};
                for (int i = `FANO_DEPTH-1; i > 0; i--)
                    node_met[i] <= node_met[i-1];
                node_met[0] <= `FANO_MET_MIN;
            end
            if (i_fwd) begin                    // Overrides the shifted value
                dec_bits[wr_idx] <= i_dec_bit;
                worse[wr_idx]    <= i_set_worse;  // Clear unless worse branch
                node_met[wr_idx] <= i_node_metric;
            end
        end
    end

    // Oldest decision leaves the window
    always_ff @(posedge clk) begin
        if (i_shift)
            o_bit <= dec_bits[`FANO_DEPTH-1];
    end

    ////////////////////////////////////////////////////
    // Reads for the current node
    ////////////////////////////////////////////////////
    assign hist_ext = {{(`FANO_K-1){1'b0}}, dec_bits};
    assign o_hist   = hist_t'(hist_ext >> i_node);  // Bits older than the branch

    // Flag of the branch just backed over
    assign o_worse = (i_node == '0) ? 1'b0 : worse[node_ptr_t'(i_node - 1'b1)];

    always_comb begin
        if (i_node == node_ptr_t'(`FANO_DEPTH-1))
            o_prev_metric = `FANO_MET_MIN;  // No predecessor left in window
        else
            o_prev_metric = node_met[node_ptr_t'(i_node + 1'b1)];
    end

endmodule

// File: sources.f
+incdir+source
source/fano_pkg.sv
source/branch_store.sv
source/path_memory.sv
source/branch_metric.sv
source/fano_control.sv
source/fano_decoder.sv
testbench/fano_decoder_asserts.sv
testbench/fano_decoder_tb.sv

// File: testbench/fano_decoder_asserts.sv
`timescale 1ns/100ps

module fano_decoder_asserts (
    input  logic                      clk,
    input  logic                      nlocal_rst,
    input  logic                      i_sym_vld,
    input  logic                      i_bit_vld,
    input  fano_pkg::search_state_e   i_state
);

    ////////////////////////////////////////////////////
    // Top-level strobes
    ////////////////////////////////////////////////////
    // Output pulse only right behind an input strobe
    bit_after_sym: assert property (@(posedge clk) disable iff (!nlocal_rst)
        i_bit_vld |-> $past(i_sym_vld))
        else $error("o_bit_vld rose without an input strobe one cycle before");

    bit_quiet_in_reset: assert property (@(posedge clk)
        !nlocal_rst |=> !i_bit_vld)                 // Sync reset clears it
        else $error("o_bit_vld high while reset is applied");

    ////////////////////////////////////////////////////
    // Controller
    ////////////////////////////////////////////////////
    state_known: assert property (@(posedge clk) disable iff (!nlocal_rst)
        !$isunknown(i_state))
        else $error("Search state is unknown");

endmodule

bind fano_decoder fano_decoder_asserts fano_decoder_asserts_inst (
    .clk        (clk),
    .nlocal_rst (nlocal_rst),
    .i_sym_vld  (i_sym_vld),
    .i_bit_vld  (o_bit_vld),
    .i_state    (fano_control_inst.state)
);

// File: testbench/fano_decoder_tb.sv
`timescale 1ns/100ps
`include "fano_defs.svh"

module fano_decoder_tb;
    import fano_pkg::*;

    localparam int CLK_PERIOD     = 40;
    localparam int RESET_CYCLES   = 10;
    localparam int TOTAL_BRANCHES = 300 + 70 + 400 + 200 + 150 + 200 + 400;

    logic               clk;
    logic               nlocal_rst;
    logic               i_sym_vld;
    sym_t               i_sym;
    metric_t            i_delta_t;
    logic               o_bit_vld;
    logic               o_bit;

    logic [`FANO_K-1:0] enc_state;      // Reference encoder state with bit 0 newest
    logic               exp_bits[$];    // Info bits still inside the window
    logic               exp_bit;
    int                 err_at[$];      // Branch numbers with one flipped bit
    int                 strobe_cnt;     // Strobes since reset
    int                 out_cnt;
    int                 first_out;      // Strobe number of first output
    bit                 strobe_seen;

    fano_decoder fano_decoder_inst (
        .clk        (clk),
        .nlocal_rst (nlocal_rst),
        .i_sym_vld  (i_sym_vld),
        .i_sym      (i_sym),
        .i_delta_t  (i_delta_t),
        .o_bit_vld  (o_bit_vld),
        .o_bit      (o_bit)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD/2) clk = ~clk;
    end

    task automatic fail_now();
        $display("Result: FAILED");
        $fatal(1, "Run stopped at the first error");
    endtask

    ////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////
    task automatic apply_reset(input metric_t delta);
        nlocal_rst = 1'b0;
        i_sym_vld  = 1'b0;
        i_delta_t  = delta;
        repeat (RESET_CYCLES) @(negedge clk);
        exp_bits.delete();                  // Fresh stream after reset
        enc_state  = '0;
        strobe_cnt = 0;
        out_cnt    = 0;
        first_out  = 0;
        nlocal_rst = 1'b1;
    endtask

    // One strobe, then idle for the rest of the gap
    task automatic send_branch(input logic info, input sym_t flip);
        enc_state = {enc_state[`FANO_K-2:0], info};
        exp_bits.push_back(info);
        i_sym     = {info, ^(enc_state & `FANO_GEN)} ^ flip;
        i_sym_vld = 1'b1;
        @(negedge clk);
        i_sym_vld = 1'b0;
        repeat (`FANO_MIN_GAP-1) @(negedge clk);
    endtask

    task automatic send_stream(input int n_branch, input bit all_zero);
        logic [31:0] rnd;
        logic        info;
        sym_t        flip;
        for (int n = 1; n <= n_branch; n++) begin
            rnd  = $urandom;
            info = all_zero ? 1'b0 : rnd[0];
            flip = 2'b00;
            foreach (err_at[j]) begin
                if (err_at[j] == n)
                    flip = (all_zero || rnd[1]) ? 2'b01 : 2'b10;  // Parity or info
            end
            send_branch(info, flip);
        end
    endtask

    task automatic check_count(input int n_sent);
        assert (out_cnt == n_sent - `FANO_DEPTH) else begin
            $display("Mismatch o_bit_vld count: expected %h, actual %h",
                     n_sent - `FANO_DEPTH, out_cnt);
            fail_now();
        end
        // First decision leaves when branch DEPTH+1 pushes it out
        assert (first_out == `FANO_DEPTH + 1) else begin
            $display("Mismatch first output strobe: expected %h, actual %h",
                     `FANO_DEPTH + 1, first_out);
            fail_now();
        end
    endtask

    ////////////////////////////////////////////////////
    // Output monitor
    ////////////////////////////////////////////////////
    always @(posedge clk) begin
        strobe_seen = (nlocal_rst === 1'b1) && (i_sym_vld === 1'b1);
        if (strobe_seen)
            strobe_cnt++;
    end

    always @(negedge clk) begin
        if (nlocal_rst === 1'b1) begin
            assert (o_bit_vld === (strobe_seen && strobe_cnt > `FANO_DEPTH)) else begin
                $display("Mismatch o_bit_vld: expected %h, actual %h",
                         strobe_seen && strobe_cnt > `FANO_DEPTH, o_bit_vld);
                fail_now();
            end
            if (o_bit_vld === 1'b1) begin
                exp_bit = exp_bits.pop_front();
                assert (o_bit === exp_bit) else begin
                    $display("Mismatch o_bit: expected %h, actual %h", exp_bit, o_bit);
                    fail_now();
                end
                if (first_out == 0)
                    first_out = strobe_cnt;
                out_cnt++;
            end
        end
    end

    ////////////////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////////////////
    task automatic clean_random_stream();
        apply_reset(2);
        send_stream(300, 1'b0);
        check_count(300);
    endtask

    task automatic output_start();
        apply_reset(2);
        send_stream(`FANO_DEPTH + 6, 1'b0);   // Just past the window fill
        check_count(`FANO_DEPTH + 6);
    endtask

    task automatic isolated_errors(input metric_t delta);
        apply_reset(delta);
        err_at = '{80, 160, 240, 320};
        send_stream(400, 1'b0);
        check_count(400);
        err_at.delete();
    endtask

    task automatic all_zero_message();
        apply_reset(2);
        err_at = '{50, 150};                  // Parity flips 100 apart
        send_stream(200, 1'b1);
        check_count(200);
        err_at.delete();
    endtask

    task automatic reset_mid_run();
        apply_reset(2);
        send_stream(150, 1'b0);
        check_count(150);
        apply_reset(2);                       // Window refills from empty
        send_stream(200, 1'b0);
        check_count(200);
    endtask

    initial begin
        nlocal_rst = 1'b0;
        i_sym_vld  = 1'b0;
        i_sym      = '0;
        i_delta_t  = 2;
        void'($urandom(32'h1505));
        clean_random_stream();
        output_start();
        isolated_errors(2);
        all_zero_message();
        reset_mid_run();
        isolated_errors(4);                   // Coarser threshold step
        $display("Result: PASSED");
        $finish;
    end

    // Watchdog sized from the branch count
    initial begin
        #((TOTAL_BRANCHES * `FANO_MIN_GAP + 8 * RESET_CYCLES + 500) * CLK_PERIOD);
        $display("Timeout: the tests did not finish in the expected time");
        fail_now();
    end

endmodule
